// File: build.f
+incdir+bench
rtl/console_bus_pkg.sv
rtl/rom_access_pkg.sv
rtl/console_bus_sync.sv
rtl/console_liveness.sv
rtl/rom_slot_arbiter.sv
rtl/brightness_limiter.sv
rtl/cart_bus_top.sv
bench/tb_cart_bus.sv

// File: run_sim.sh
#!/bin/sh
# build and run the cart bus testbench with Verilator
verilator --binary --timing --assert --top-module tb_cart_bus -f build.f \
  -Mdir obj_dir -o sim_cart_bus && ./obj_dir/sim_cart_bus > sim.log 2>&1
cat sim.log
grep -qx "ALL CHECKS PASSED" sim.log && echo "simulation passed" || {
  echo "simulation failed"
  exit 1
}

// File: bench/tb_cart_vectors.svh
`ifndef TB_CART_VECTORS_SVH
`define TB_CART_VECTORS_SVH

// kinds of table entries
typedef enum logic [2:0] {
  V_MCU_WR,
  V_MCU_RD,
  V_HOLD_WR,
  V_CLK_START,
  V_CONS_RD,
  V_BRIGHT,
  V_LIVE_RD
} vec_op_t;

// exp holds the forced byte, or the reset pulse count, where a fixed value applies
typedef struct packed {
  vec_op_t     op;
  logic [23:0] addr;
  logic [7:0]  data;
  logic [7:0]  exp;
} vec_t;

localparam int N_VEC = 15;

vec_t vectors [N_VEC];

task automatic load_vectors();
  // dead console, both byte lanes of one word
  vectors[0]  = '{V_MCU_WR,    24'h000100, 8'h00, 8'h00};
  vectors[1]  = '{V_MCU_WR,    24'h000101, 8'h00, 8'h00};
  vectors[2]  = '{V_MCU_WR,    24'h7ffffe, 8'h00, 8'h00};
  vectors[3]  = '{V_MCU_RD,    24'h000100, 8'h00, 8'h00};
  vectors[4]  = '{V_MCU_RD,    24'h000101, 8'h00, 8'h00};
  vectors[5]  = '{V_MCU_RD,    24'h7ffffe, 8'h00, 8'h00};
  vectors[6]  = '{V_MCU_RD,    24'h7fffff, 8'h00, 8'h00};
  vectors[7]  = '{V_HOLD_WR,   24'h000200, 8'h00, 8'h01};
  vectors[8]  = '{V_MCU_RD,    24'h000200, 8'h00, 8'h00};
  // console wakes up here
  vectors[9]  = '{V_CLK_START, 24'h000000, 8'h00, 8'h01};
  vectors[10] = '{V_CONS_RD,   24'hc01235, 8'h00, 8'h00};
  vectors[11] = '{V_CONS_RD,   24'h000101, 8'h00, 8'h00};
  vectors[12] = '{V_BRIGHT,    24'h000000, 8'h8f, 8'h89};
  vectors[13] = '{V_BRIGHT,    24'h000000, 8'h05, 8'h00};
  vectors[14] = '{V_LIVE_RD,   24'h000100, 8'h00, 8'h00};
endtask

// fibonacci LFSR, taps 32 22 2 1
function automatic logic [31:0] lfsr_step(input logic [31:0] s);
  return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
endfunction

`endif

// File: bench/tb_cart_bus.sv
`timescale 1ns/100ps

module tb_cart_bus
  import console_bus_pkg::*;
();

  `include "tb_cart_vectors.svh"

  logic CLK2, rst_n;
  logic read_pin, write_pin, cpu_clk_pin, romsel_pin, pawr_pin;
  logic [23:0] addr_pin;
  logic [7:0]  pa_pin;
  logic [7:0]  din_pin;
  logic [3:0]  bright_limit;
  logic        mcu_valid, mcu_write;
  logic [23:0] mcu_addr;
  logic [7:0]  mcu_wdata;
  logic [15:0] rom_din;
  logic        mcu_ready;
  logic [7:0]  mcu_rdata;
  logic [22:0] rom_addr;
  logic [15:0] rom_dout;
  logic        rom_dout_en, rom_we_n, rom_bhe_n, rom_ble_n;
  logic [7:0]  console_dout;
  logic        console_dir, console_oe_n, snes_reset;

  localparam int CYCLE_LIMIT = N_VEC * 200 + int'(DEAD_TIMEOUT) + 1000;

  logic [15:0] rom_mem [int];
  logic [7:0]  shadow [int];
  logic [31:0] lfsr;
  logic        we_prev;
  logic        clk_run;
  int          cpu_div;
  int          store_bursts;
  int          reset_pulses;
  int          cycle_cnt;
  int          errors;
  int          checks;

  cart_bus_top dut0 (.*);

  initial begin
    CLK2 = 1'b0;
    forever #20 CLK2 = ~CLK2;
  end

  // run limit
  always @(posedge CLK2) begin
    cycle_cnt++;
    if (cycle_cnt > CYCLE_LIMIT) begin
      $display("timeout: run went past %0d cycles without finishing", CYCLE_LIMIT);
      $display("CHECKS FAILED");
      $finish;
    end
  end

  ////////////////////////////////////////
  // ROM model, away from the DUT edge
  ////////////////////////////////////////
  function automatic logic [15:0] fill_word(input logic [22:0] w);
    return w[15:0] ^ {w[6:0], w[22:14]};
  endfunction

  function automatic logic [15:0] rom_word(input logic [22:0] w);
    if (rom_mem.exists(int'(w))) begin
      return rom_mem[int'(w)];
    end
    return fill_word(w);
  endfunction

  always @(negedge CLK2) begin
    if (!rom_we_n) begin
      logic [15:0] w;
      w = rom_word(rom_addr);
      if (!rom_bhe_n) w[15:8] = rom_dout[15:8];
      if (!rom_ble_n) w[7:0] = rom_dout[7:0];
      rom_mem[int'(rom_addr)] = w;
      if (we_prev) store_bursts++;
      check_true(rom_dout_en, "ROM data bus not driven during a write");
    end
    we_prev = rom_we_n;
    if (snes_reset) reset_pulses++;
    rom_din <= rom_word(rom_addr);
  end

  // cpu clock, 12 CLK2 cycles per phase
  always @(posedge CLK2) begin
    #2;
    if (clk_run) begin
      if (cpu_div == 11) begin
        cpu_div = 0;
        cpu_clk_pin = ~cpu_clk_pin;
      end else begin
        cpu_div++;
      end
    end
  end

  ////////////////////////////////////////
  // helpers
  ////////////////////////////////////////
  // leaves the caller 1 ns after the edge, drives go 1 ns later
  task automatic next_cycle();
    @(posedge CLK2);
    #1;
  endtask

  task automatic wait_cycles(input int n);
    for (int k = 0; k < n; k++) next_cycle();
  endtask

  task automatic check_value(input string name, input logic [31:0] got,
                             input logic [31:0] exp);
    checks++;
    assert (got === exp) else begin
      $display("error t=%0t %s got %h exp %h", $time, name, got, exp);
      errors++;
    end
  endtask

  task automatic check_true(input logic cond, input string what);
    checks++;
    assert (cond) else begin
      $display("failure at t=%0t: %s", $time, what);
      errors++;
    end
  endtask

  task automatic random_byte(output logic [7:0] b);
    b = '0;
    for (int k = 0; k < 8; k++) begin
      lfsr = lfsr_step(lfsr);
      b = {b[6:0], lfsr[0]};
    end
  endtask

  function automatic logic [7:0] expected_byte(input logic [23:0] a);
    logic [15:0] w;
    if (shadow.exists(int'(a))) begin
      return shadow[int'(a)];
    end
    w = fill_word(a[23:1]);
    return a[0] ? w[7:0] : w[15:8];
  endfunction

  // one valid/ready transfer, hold keeps valid up through the busy time
  task automatic mcu_access(input logic wr, input logic [23:0] a, input logic [7:0] wd,
                            input bit hold, input int max_lat, output logic [7:0] rd);
    logic r;
    int   lat;
    next_cycle();
    r = mcu_ready;
    #1;
    mcu_valid = 1'b1;
    mcu_write = wr;
    mcu_addr  = a;
    mcu_wdata = wd;
    lat = 0;
    while (1) begin
      next_cycle();
      if (r) break;
      r = mcu_ready;
      lat++;
      if (lat > 200) break;
    end
    check_true(lat <= 200, "request was never accepted");
    check_value("mcu_ready", {31'd0, mcu_ready}, 32'd0);
    if (!hold) begin
      #1;
      mcu_valid = 1'b0;
    end
    lat = 0;
    while (!mcu_ready && lat <= max_lat + 20) begin
      next_cycle();
      lat++;
    end
    check_true(lat <= max_lat, "access did not complete in time");
    if (hold) begin
      #1;
      mcu_valid = 1'b0;
    end
    rd = mcu_rdata;
  endtask

  ////////////////////////////////////////
  // console side
  ////////////////////////////////////////
  task automatic console_read(input logic [23:0] a);
    logic [23:0] m;
    logic [15:0] w;
    logic [7:0]  exp;
    next_cycle();
    #1;
    addr_pin   = a;
    romsel_pin = 1'b0;
    wait_cycles(8);
    #1;
    read_pin = 1'b0;
    for (int k = 0; k < 20; k++) begin
      next_cycle();
      if (k == 17) begin
        m   = a & 24'h7fffff;
        w   = rom_word(m[23:1]);
        exp = m[0] ? w[7:0] : w[15:8];
        check_value("console_dir", {31'd0, console_dir}, 32'd1);
        check_value("console_oe_n", {31'd0, console_oe_n}, 32'd0);
        check_value("console_dout", {24'd0, console_dout}, {24'd0, exp});
      end
    end
    #1;
    read_pin   = 1'b1;
    romsel_pin = 1'b1;
    wait_cycles(6);
    // bus handed back to the console
    check_value("console_dir", {31'd0, console_dir}, 32'd0);
    check_value("console_oe_n", {31'd0, console_oe_n}, 32'd1);
  endtask

  task automatic bright_write(input logic [7:0] d, input logic [7:0] exp);
    logic seen;
    logic prev;
    int   k;
    seen = 1'b0;
    next_cycle();
    #1;
    pa_pin  = 8'h00;
    din_pin = d;
    wait_cycles(8);
    // line the write up with a fresh cpu cycle
    prev = cpu_clk_pin;
    k = 0;
    while (!(cpu_clk_pin && !prev) && k < 40) begin
      prev = cpu_clk_pin;
      next_cycle();
      k++;
    end
    check_true(k < 40, "no rising cpu clock edge before the brightness write");
    #1;
    pawr_pin = 1'b0;
    for (int c = 0; c < 12; c++) begin
      next_cycle();
      if (c == 8) begin
        #1;
        pawr_pin = 1'b1;
      end
      if (console_dir) begin
        seen = 1'b1;
        check_value("console_dout", {24'd0, console_dout}, {24'd0, exp});
      end
    end
    if (exp != 8'h00) begin
      check_true(seen, "brightness write was not overridden");
    end else begin
      check_true(!seen, "cart drove the bus on a brightness write below the limit");
    end
    #1;
    pa_pin = 8'hff;
    wait_cycles(30);
  endtask

  ////////////////////////////////////////
  // main sequence
  ////////////////////////////////////////
  initial begin
    logic [7:0] b;
    logic [7:0] got;
    int         err_before;
    int         n_before;
    read_pin = 1'b1;
    write_pin = 1'b1;
    cpu_clk_pin = 1'b0;
    romsel_pin = 1'b1;
    pawr_pin = 1'b1;
    addr_pin = '0;
    pa_pin = 8'hff;
    din_pin = '0;
    bright_limit = 4'd9;
    mcu_valid = 1'b0;
    mcu_write = 1'b0;
    mcu_addr = '0;
    mcu_wdata = '0;
    rom_din = '0;
    rst_n = 1'b0;
    lfsr = 32'ha8970f58;
    we_prev = 1'b1;
    clk_run = 1'b0;
    cpu_div = 0;
    store_bursts = 0;
    reset_pulses = 0;
    cycle_cnt = 0;
    errors = 0;
    checks = 0;
    load_vectors();
    wait_cycles(10);
    #1;
    rst_n = 1'b1;
    wait_cycles(4);

    for (int i = 0; i < N_VEC; i++) begin
      err_before = errors;
      case (vectors[i].op)
        V_MCU_WR: begin
          random_byte(b);
          mcu_access(1'b1, vectors[i].addr, b, 1'b0, 12, got);
          shadow[int'(vectors[i].addr)] = b;
        end
        V_MCU_RD: begin
          mcu_access(1'b0, vectors[i].addr, 8'h00, 1'b0, 12, got);
          check_value("mcu_rdata", {24'd0, got}, {24'd0, expected_byte(vectors[i].addr)});
        end
        V_HOLD_WR: begin
          random_byte(b);
          n_before = store_bursts;
          mcu_access(1'b1, vectors[i].addr, b, 1'b1, 12, got);
          wait_cycles(4);
          shadow[int'(vectors[i].addr)] = b;
          check_value("store_bursts", store_bursts - n_before, {24'd0, vectors[i].exp});
        end
        V_CLK_START: begin
          n_before = reset_pulses;
          clk_run = 1'b1;
          wait_cycles(100);
          check_value("snes_reset", reset_pulses - n_before, {24'd0, vectors[i].exp});
        end
        V_CONS_RD: begin
          console_read(vectors[i].addr);
        end
        V_BRIGHT: begin
          bright_write(vectors[i].data, vectors[i].exp);
        end
        default: begin
          mcu_access(1'b0, vectors[i].addr, 8'h00, 1'b0, 150, got);
          check_value("mcu_rdata", {24'd0, got}, {24'd0, expected_byte(vectors[i].addr)});
        end
      endcase
      $display("test %0d %s %s", i, vectors[i].op.name(), (errors == err_before) ? "ok" : "fail");
    end

    $display("checks %0d errors %0d", checks, errors);
    if (errors == 0) begin
      $display("ALL CHECKS PASSED");
    end else begin
      $display("CHECKS FAILED");
    end
    $finish;
  end

endmodule

// File: rtl/cart_bus_top.sv
`timescale 1ns/100ps

module cart_bus_top
  import console_bus_pkg::*;
  import rom_access_pkg::*;
(
  input  logic                       CLK2,
  input  logic                       rst_n,
  input  logic                       read_pin,
  input  logic                       write_pin,
  input  logic                       cpu_clk_pin,
  input  logic                       romsel_pin,
  input  logic                       pawr_pin,
  input  logic [CONSOLE_ADDR_W-1:0]  addr_pin,
  input  logic [PA_W-1:0]            pa_pin,
  input  logic [DATA_W-1:0]          din_pin,
  input  logic [BRIGHT_W-1:0]        bright_limit,
  input  logic                       mcu_valid,
  input  logic                       mcu_write,
  input  logic [ROM_BYTE_ADDR_W-1:0] mcu_addr,
  input  logic [DATA_W-1:0]          mcu_wdata,
  input  logic [ROM_DATA_W-1:0]      rom_din,
  output logic                       mcu_ready,
  output logic [DATA_W-1:0]          mcu_rdata,
  output logic [ROM_ADDR_W-1:0]      rom_addr,
  output logic [ROM_DATA_W-1:0]      rom_dout,
  output logic                       rom_dout_en,
  output logic                       rom_we_n,
  output logic                       rom_bhe_n,
  output logic                       rom_ble_n,
  output logic [DATA_W-1:0]          console_dout,
  output logic                       console_dir,
  output logic                       console_oe_n,
  output logic                       snes_reset
);

  logic rd_level;
  logic romsel_level;
  logic pawr_level;
  logic rd_start;
  logic pawr_start;
  logic cycle_start;
  logic cycle_end;
  logic cpu_clk_sample;
  logic [CONSOLE_ADDR_W-1:0] addr;
  logic [PA_W-1:0]           pa;
  logic [DATA_W-1:0]         din;
  logic console_dead;
  logic rom_hit;
  logic rom_byte_sel;
  logic mcu_drive;
  logic force_active;
  logic [DATA_W-1:0] force_data;
  logic [ROM_BYTE_ADDR_W-1:0] console_rom_addr;
  logic [DATA_W-1:0] rom_byte;
  logic console_read;
  logic force_drive;

  console_bus_sync sync0 (
    .CLK2(CLK2), .rst_n(rst_n),
    .read_pin(read_pin), .write_pin(write_pin), .cpu_clk_pin(cpu_clk_pin),
    .romsel_pin(romsel_pin), .pawr_pin(pawr_pin),
    .addr_pin(addr_pin), .pa_pin(pa_pin), .din_pin(din_pin),
    .rd_level(rd_level), .wr_level(), .cpu_clk_level(),
    .romsel_level(romsel_level), .pawr_level(pawr_level),
    .rd_start(rd_start), .rd_end(), .wr_end(), .pawr_start(pawr_start),
    .cycle_start(cycle_start), .cycle_end(cycle_end),
    .cpu_clk_sample(cpu_clk_sample),
    .addr(addr), .pa(pa), .din(din)
  );

  console_liveness live0 (
    .CLK2(CLK2), .rst_n(rst_n), .cpu_clk_sample(cpu_clk_sample),
    .console_dead(console_dead), .snes_reset(snes_reset)
  );

  ////////////////////////////////////////
  // ROM bus
  ////////////////////////////////////////
  assign rom_hit          = ~romsel_level;
  assign console_rom_addr = addr & ROM_ADDR_MASK;

  rom_slot_arbiter arb0 (
    .CLK2(CLK2), .rst_n(rst_n),
    .cycle_start(cycle_start), .cycle_end(cycle_end), .rom_hit(rom_hit),
    .console_dead(console_dead), .cpu_clk_sample(cpu_clk_sample),
    .mcu_valid(mcu_valid), .mcu_write(mcu_write),
    .mcu_addr(mcu_addr), .mcu_wdata(mcu_wdata),
    .console_rom_addr(console_rom_addr), .rom_din(rom_din),
    .mcu_ready(mcu_ready), .mcu_rdata(mcu_rdata),
    .rom_addr(rom_addr), .rom_byte_sel(rom_byte_sel),
    .rom_we_n(rom_we_n), .mcu_drive(mcu_drive)
  );

  // byte on both lanes, the lane strobes pick the target
  assign rom_dout    = {mcu_rdata, mcu_rdata};
  assign rom_dout_en = mcu_drive;
  assign rom_bhe_n   = rom_byte_sel;
  assign rom_ble_n   = ~rom_byte_sel;
  assign rom_byte    = rom_byte_sel ? rom_din[7:0] : rom_din[15:8];

  brightness_limiter lim0 (
    .CLK2(CLK2), .rst_n(rst_n),
    .pawr_start(pawr_start), .cycle_end(cycle_end),
    .pa(pa), .din(din), .bright_limit(bright_limit),
    .force_active(force_active), .force_data(force_data)
  );

  ////////////////////////////////////////
  // console data bus
  ////////////////////////////////////////
  // cart drives only for ROM reads or a forced brightness write
  assign console_read = ~rd_level & rom_hit;
  assign force_drive  = force_active & ~pawr_level;
  assign console_dir  = console_read | force_drive;
  assign console_oe_n = ~console_dir;
  assign console_dout = force_drive ? force_data : rom_byte;

  // a ROM read should never start while the cart is driving a forced value
  a_no_read_during_force: assert property (
    @(posedge CLK2) disable iff (!rst_n) (rd_start && rom_hit) |-> !force_drive
  );

endmodule

// File: rtl/brightness_limiter.sv
`timescale 1ns/100ps

module brightness_limiter
  import console_bus_pkg::*;
(
  input  logic                CLK2,
  input  logic                rst_n,
  input  logic                pawr_start,
  input  logic                cycle_end,
  input  logic [PA_W-1:0]     pa,
  input  logic [DATA_W-1:0]   din,
  input  logic [BRIGHT_W-1:0] bright_limit,
  output logic                force_active,
  output logic [DATA_W-1:0]   force_data
);

  logic [BRIGHT_W-1:0] bright_in;
  logic                limit_on;
  logic                bright_hit;
  logic                over_limit;

  assign bright_in = din[BRIGHT_W-1:0];

  // full scale limit means no limiting
  assign limit_on   = (bright_limit != '1);
  assign bright_hit = pawr_start && (pa == PA_BRIGHTNESS);
  assign over_limit = limit_on && (bright_in > bright_limit);

  ////////////////////////////////////////
  // force window
  ////////////////////////////////////////
  // held from the snooped write until the cpu cycle ends
  always_ff @(posedge CLK2) begin
    if (!rst_n) begin
      force_active <= 1'b0;
    end else if (cycle_end) begin
      force_active <= 1'b0;
    end else if (bright_hit && over_limit) begin
      force_active <= 1'b1;
    end
  end

  // keep forced blank and unused bits, clamp the level
  always_ff @(posedge CLK2) begin
    if (bright_hit && over_limit) begin
      force_data <= {din[DATA_W-1:BRIGHT_W], bright_limit};
    end
  end

endmodule

// File: rtl/rom_slot_arbiter.sv
`timescale 1ns/100ps

module rom_slot_arbiter
  import console_bus_pkg::*;
  import rom_access_pkg::*;
(
  input  logic                       CLK2,
  input  logic                       rst_n,
  input  logic                       cycle_start,
  input  logic                       cycle_end,
  input  logic                       rom_hit,
  input  logic                       console_dead,
  input  logic                       cpu_clk_sample,
  input  logic                       mcu_valid,
  input  logic                       mcu_write,
  input  logic [ROM_BYTE_ADDR_W-1:0] mcu_addr,
  input  logic [DATA_W-1:0]          mcu_wdata,
  input  logic [ROM_BYTE_ADDR_W-1:0] console_rom_addr,
  input  logic [ROM_DATA_W-1:0]      rom_din,
  output logic                       mcu_ready,
  output logic [DATA_W-1:0]          mcu_rdata,
  output logic [ROM_ADDR_W-1:0]      rom_addr,
  output logic                       rom_byte_sel,
  output logic                       rom_we_n,
  output logic                       mcu_drive
);

  slot_state_t           state;
  logic [ROM_DELAY_W-1:0] delay_q;
  logic                  pend_q;
  rom_op_t               pend_op;
  logic [ROM_BYTE_ADDR_W-1:0] addr_q;
  logic                  free_strobe;
  logic                  free_slot;
  logic                  accept;
  logic                  mcu_hit;
  logic                  revive;

  assign accept  = mcu_valid & mcu_ready;
  assign mcu_hit = (state == ST_RD_ACCESS) || (state == ST_WR_ACCESS);
  assign revive  = console_dead & cpu_clk_sample;

  ////////////////////////////////////////
  // free slot detection
  ////////////////////////////////////////
  // a cycle that does not touch ROM frees the bus one cycle after its start
  always_ff @(posedge CLK2) begin
    if (!rst_n) begin
      free_strobe <= 1'b0;
    end else begin
      free_strobe <= cycle_start & ~rom_hit;
    end
  end

  assign free_slot = cycle_end | free_strobe;

  // request latch and handshake
  always_ff @(posedge CLK2) begin
    if (!rst_n) begin
      pend_q    <= 1'b0;
      mcu_ready <= 1'b1;
    end else if (accept) begin
      pend_q    <= 1'b1;
      mcu_ready <= 1'b0;
    end else if (state == ST_RD_END || state == ST_WR_END) begin
      pend_q    <= 1'b0;
      mcu_ready <= 1'b1;
    end
  end

  always_ff @(posedge CLK2) begin
    if (accept) begin
      pend_op <= rom_op_t'(mcu_write);
      addr_q  <= mcu_addr;
    end
  end

  ////////////////////////////////////////
  // access FSM
  ////////////////////////////////////////
  always_ff @(posedge CLK2) begin
    if (!rst_n) begin
      state   <= ST_IDLE;
      delay_q <= '0;
    end else if (revive) begin
      // console woke up mid access, restart on a proper slot
      state <= ST_IDLE;
    end else begin
      case (state)
        ST_IDLE: begin
          if (pend_q && (free_slot || console_dead)) begin
            state   <= (pend_op == OP_WRITE) ? ST_WR_ACCESS : ST_RD_ACCESS;
            delay_q <= ROM_CYCLE_LEN;
          end
        end
        ST_RD_ACCESS, ST_WR_ACCESS: begin
          delay_q <= delay_q - 1'b1;
          if (delay_q == '0) begin
            state <= (state == ST_WR_ACCESS) ? ST_WR_END : ST_RD_END;
          end
        end
        default: state <= ST_IDLE;
      endcase
    end
  end

  // write byte parks here too, the top drives it onto the ROM lanes
  always_ff @(posedge CLK2) begin
    if (accept && mcu_write) begin
      mcu_rdata <= mcu_wdata;
    end else if (state == ST_RD_ACCESS) begin
      mcu_rdata <= addr_q[0] ? rom_din[7:0] : rom_din[15:8];
    end
  end

  // console address passes through between accesses
  assign rom_addr     = mcu_hit ? addr_q[ROM_BYTE_ADDR_W-1:1]
                                : console_rom_addr[ROM_BYTE_ADDR_W-1:1];
  assign rom_byte_sel = mcu_hit ? addr_q[0] : console_rom_addr[0];
  assign mcu_drive    = (state == ST_WR_ACCESS);
  assign rom_we_n     = ~mcu_drive;

  a_busy_in_access: assert property (
    @(posedge CLK2) disable iff (!rst_n) mcu_hit |-> !mcu_ready
  );

  a_we_only_for_write: assert property (
    @(posedge CLK2) disable iff (!rst_n) !rom_we_n |-> (pend_q && pend_op == OP_WRITE)
  );

endmodule

// File: rtl/console_liveness.sv
`timescale 1ns/100ps

module console_liveness
  import console_bus_pkg::*;
(
  input  logic CLK2,
  input  logic rst_n,
  input  logic cpu_clk_sample,
  output logic console_dead,
  output logic snes_reset
);

  logic [DEAD_CNT_W-1:0] dead_cnt;

  // low time of the cpu clock, saturating
  always_ff @(posedge CLK2) begin
    if (!rst_n) begin
      dead_cnt <= '0;
    end else if (cpu_clk_sample) begin
      dead_cnt <= '0;
    end else if (dead_cnt != '1) begin
      dead_cnt <= dead_cnt + 1'b1;
    end
  end

  ////////////////////////////////////////
  // dead flag and revival strobe
  ////////////////////////////////////////
  always_ff @(posedge CLK2) begin
    if (!rst_n) begin
      console_dead <= 1'b1;
      snes_reset   <= 1'b0;
    end else if (cpu_clk_sample) begin
      console_dead <= 1'b0;
      // first clock seen after death
      snes_reset   <= console_dead;
    end else begin
      snes_reset <= 1'b0;
      if (dead_cnt > DEAD_TIMEOUT) begin
        console_dead <= 1'b1;
      end
    end
  end

endmodule

// File: rtl/console_bus_sync.sv
`timescale 1ns/100ps

module console_bus_sync
  import console_bus_pkg::*;
(
  input  logic                      CLK2,
  input  logic                      rst_n,
  input  logic                      read_pin,
  input  logic                      write_pin,
  input  logic                      cpu_clk_pin,
  input  logic                      romsel_pin,
  input  logic                      pawr_pin,
  input  logic [CONSOLE_ADDR_W-1:0] addr_pin,
  input  logic [PA_W-1:0]           pa_pin,
  input  logic [DATA_W-1:0]         din_pin,
  output logic                      rd_level,
  output logic                      wr_level,
  output logic                      cpu_clk_level,
  output logic                      romsel_level,
  output logic                      pawr_level,
  output logic                      rd_start,
  output logic                      rd_end,
  output logic                      wr_end,
  output logic                      pawr_start,
  output logic                      cycle_start,
  output logic                      cycle_end,
  output logic                      cpu_clk_sample,
  output logic [CONSOLE_ADDR_W-1:0] addr,
  output logic [PA_W-1:0]           pa,
  output logic [DATA_W-1:0]         din
);

  logic [SYNC_DEPTH-1:0] rd_q;
  logic [SYNC_DEPTH-1:0] wr_q;
  logic [SYNC_DEPTH-1:0] clk_q;
  logic [SYNC_DEPTH-1:0] romsel_q;
  logic [SYNC_DEPTH-1:0] pawr_q;
  logic [CONSOLE_ADDR_W-1:0] addr_q [ADDR_DELAY];
  logic [PA_W-1:0]           pa_q   [ADDR_DELAY];
  logic [DATA_W-1:0]         data_q [DATA_DELAY];

  // strobes idle high, cpu clock idles low on a dead console
  always_ff @(posedge CLK2) begin
    if (!rst_n) begin
      rd_q     <= '1;
      wr_q     <= '1;
      romsel_q <= '1;
      pawr_q   <= '1;
      clk_q    <= '0;
    end else begin
      rd_q     <= {rd_q[SYNC_DEPTH-2:0], read_pin};
      wr_q     <= {wr_q[SYNC_DEPTH-2:0], write_pin};
      romsel_q <= {romsel_q[SYNC_DEPTH-2:0], romsel_pin};
      pawr_q   <= {pawr_q[SYNC_DEPTH-2:0], pawr_pin};
      clk_q    <= {clk_q[SYNC_DEPTH-2:0], cpu_clk_pin};
    end
  end

  always_ff @(posedge CLK2) begin
    addr_q[0] <= addr_pin;
    pa_q[0]   <= pa_pin;
    for (int i = 1; i < ADDR_DELAY; i++) begin
      addr_q[i] <= addr_q[i-1];
      pa_q[i]   <= pa_q[i-1];
    end
    data_q[0] <= din_pin;
    for (int j = 1; j < DATA_DELAY; j++) begin
      data_q[j] <= data_q[j-1];
    end
  end

  ////////////////////////////////////////
  // filtered levels, two cycles behind
  ////////////////////////////////////////
  assign rd_level       = rd_q[2] & rd_q[1];
  assign wr_level       = wr_q[2] & wr_q[1];
  assign cpu_clk_level  = clk_q[2] & clk_q[1];
  assign romsel_level   = romsel_q[2] & romsel_q[1];
  assign pawr_level     = pawr_q[2] & pawr_q[1];
  assign cpu_clk_sample = clk_q[1];

  ////////////////////////////////////////
  // edge strobes over six samples
  ////////////////////////////////////////
  // OR of neighbours rejects single low glitches, AND rejects high ones
  assign rd_start    = ((rd_q[6:1] | rd_q[7:2]) == 6'b111100);
  assign rd_end      = ((rd_q[6:1] & rd_q[7:2]) == 6'b000001);
  assign wr_end      = ((wr_q[6:1] & wr_q[7:2]) == 6'b000001);
  // three low samples so the data chain already holds the written byte
  assign pawr_start  = ((pawr_q[6:1] | pawr_q[7:2]) == 6'b111000);
  assign cycle_start = ((clk_q[7:2] & clk_q[6:1]) == 6'b000011);
  assign cycle_end   = ((clk_q[7:2] | clk_q[6:1]) == 6'b111000);

  // address six cycles behind, data three
  assign addr = addr_q[6] & addr_q[5];
  assign pa   = pa_q[6] & pa_q[5];
  assign din  = data_q[3] & data_q[2];

  a_rd_edges_exclusive: assert property (
    @(posedge CLK2) disable iff (!rst_n) !(rd_start && rd_end)
  );

endmodule

// File: rtl/rom_access_pkg.sv
package rom_access_pkg;

  ////////////////////////////////////////
  // ROM bus geometry
  ////////////////////////////////////////
  // word address, byte lane comes from bit 0 of the byte address
  localparam int ROM_ADDR_W = 23;
  localparam int ROM_BYTE_ADDR_W = 24;
  localparam int ROM_DATA_W = 16;

  // keeps the low 23 bits of a console byte address
  localparam logic [ROM_BYTE_ADDR_W-1:0] ROM_ADDR_MASK = 24'h7f_ffff;

  // access delay counter
  localparam int ROM_DELAY_W = 4;
  localparam logic [ROM_DELAY_W-1:0] ROM_CYCLE_LEN = 4'd7;

  ////////////////////////////////////////
  // arbiter states and access opcodes
  ////////////////////////////////////////
  typedef enum logic [2:0] {
    ST_IDLE,
    ST_RD_ACCESS,
    ST_RD_END,
    ST_WR_ACCESS,
    ST_WR_END
  } slot_state_t;

  // carried by the microcontroller write flag
  typedef enum logic {
    OP_READ  = 1'b0,
    OP_WRITE = 1'b1
  } rom_op_t;

endpackage

// File: rtl/console_bus_pkg.sv
package console_bus_pkg;

  ////////////////////////////////////////
  // console bus widths
  ////////////////////////////////////////
  localparam int CONSOLE_ADDR_W = 24;
  localparam int PA_W = 8;
  localparam int DATA_W = 8;

  // sample chain lengths on CLK2
  localparam int SYNC_DEPTH = 8;
  localparam int ADDR_DELAY = 7;
  localparam int DATA_DELAY = 5;

  ////////////////////////////////////////
  // liveness
  ////////////////////////////////////////
  localparam int DEAD_CNT_W = 18;
  // one millisecond at 96 MHz
  localparam logic [DEAD_CNT_W-1:0] DEAD_TIMEOUT = 18'd96000;

  ////////////////////////////////////////
  // peripheral registers
  ////////////////////////////////////////
  // screen brightness, low nibble is the level
  localparam logic [PA_W-1:0] PA_BRIGHTNESS = 8'h00;
  localparam int BRIGHT_W = 4;

endpackage
